/* design/cpuTypesPkg.sv */
package cpuTypesPkg;

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    SLTIU = 6'h0b,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcodeT;

  // function field of r-type words, instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } functT;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL
  } aluOpT;

  typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extModeT;
  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JREG} pcSrcT;
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstT;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSrcT;

  // raw fields sliced out of the instruction word
  typedef struct packed {
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic [25:0] target26;
  } instrFieldsT;

  typedef struct packed {
    aluOpT   aluOp;
    logic    aluSrcImm;    // operand b from immediate
    logic    aluSrcShamt;  // shift: a = rt, b = shamt
    extModeT extMode;
    logic    regWr;
    regDstT  regDst;
    wbSrcT   wbSrc;
    logic    memRead;
    logic    memWrite;
    pcSrcT   pcSrc;
    logic    isBranch;
    logic    branchOnZero; // 1 for beq, 0 for bne
  } ctrlT;

endpackage

/* design/controlUnit.sv */
module controlUnit import cpuTypesPkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic [31:0] instr,
  output instrFieldsT fields,
  output ctrlT        ctrl,
  output logic        halt
);

  opcodeT opcode;
  functT  funct;

  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = functT'(instr[5:0]);

  assign fields.rs       = instr[25:21];
  assign fields.rt       = instr[20:16];
  assign fields.rd       = instr[15:11];
  assign fields.shamt    = instr[10:6];
  assign fields.imm16    = instr[15:0];
  assign fields.target26 = instr[25:0];

  always_comb begin
    // defaults describe a no-op
    ctrl.aluOp        = ALU_ADD;
    ctrl.aluSrcImm    = 1'b0;
    ctrl.aluSrcShamt  = 1'b0;
    ctrl.extMode      = EXT_SIGN;
    ctrl.regWr        = 1'b0;
    ctrl.regDst       = DST_RT;
    ctrl.wbSrc        = WB_ALU;
    ctrl.memRead      = 1'b0;
    ctrl.memWrite     = 1'b0;
    ctrl.pcSrc        = PC_SEQ;
    ctrl.isBranch     = 1'b0;
    ctrl.branchOnZero = 1'b0;

    case (opcode)
      RTYPE: begin
        ctrl.regWr  = 1'b1;
        ctrl.regDst = DST_RD;
        case (funct)
          ADD, ADDU: ctrl.aluOp = ALU_ADD; // no overflow trap
          SUB, SUBU: ctrl.aluOp = ALU_SUB;
          AND:       ctrl.aluOp = ALU_AND;
          OR:        ctrl.aluOp = ALU_OR;
          XOR:       ctrl.aluOp = ALU_XOR;
          NOR:       ctrl.aluOp = ALU_NOR;
          SLT:       ctrl.aluOp = ALU_SLT;
          SLTU:      ctrl.aluOp = ALU_SLTU;
          SLL: begin
            ctrl.aluOp       = ALU_SLL;
            ctrl.aluSrcShamt = 1'b1;
          end
          SRL: begin
            ctrl.aluOp       = ALU_SRL;
            ctrl.aluSrcShamt = 1'b1;
          end
          JR: begin
            ctrl.regWr = 1'b0;
            ctrl.pcSrc = PC_JREG;
          end
          default: ctrl.regWr = 1'b0; // unknown funct, no-op
        endcase
      end
      J: ctrl.pcSrc = PC_JUMP;
      JAL: begin
        ctrl.pcSrc  = PC_JUMP;
        ctrl.regWr  = 1'b1;
        ctrl.regDst = DST_RA;
        ctrl.wbSrc  = WB_LINK;
      end
      BEQ, BNE: begin
        ctrl.aluOp        = ALU_SUB; // rs - rt, then look at zero
        ctrl.pcSrc        = PC_BRANCH;
        ctrl.isBranch     = 1'b1;
        ctrl.branchOnZero = (opcode == BEQ);
      end
      ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWr     = 1'b1;
        case (opcode)
          SLTI:    ctrl.aluOp = ALU_SLT;
          SLTIU:   ctrl.aluOp = ALU_SLTU; // still sign extended
          ANDI:    ctrl.aluOp = ALU_AND;
          ORI:     ctrl.aluOp = ALU_OR;
          XORI:    ctrl.aluOp = ALU_XOR;
          default: ctrl.aluOp = ALU_ADD;  // addiu, lui
        endcase
        if (opcode == ANDI || opcode == ORI || opcode == XORI)
          ctrl.extMode = EXT_ZERO;
        else if (opcode == LUI)
          ctrl.extMode = EXT_UPPER;  // rs is zero in lui
      end
      LW: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.regWr     = 1'b1;
        ctrl.wbSrc     = WB_MEM;
      end
      SW: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      default: ; // halt and unknown opcodes change nothing
    endcase
  end

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (opcode == HALT) begin
      halt <= 1'b1;
    end
  end

endmodule

/* design/aluUnit.sv */
module aluUnit import cpuTypesPkg::*; #(
  parameter int dataWidth = 32
) (
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  instrFieldsT          fields,
  input  ctrlT                 ctrl,
  output logic [dataWidth-1:0] aluResult,
  output logic                 zero
);

  logic [dataWidth-1:0] extImm;
  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;

  always_comb begin
    case (ctrl.extMode)
      EXT_ZERO:  extImm = {{(dataWidth-16){1'b0}}, fields.imm16};
      EXT_UPPER: extImm = {fields.imm16, {(dataWidth-16){1'b0}}};
      default:   extImm = {{(dataWidth-16){fields.imm16[15]}}, fields.imm16};
    endcase
  end

  // shifts take rt as the value and shamt as the distance
  always_comb begin
    if (ctrl.aluSrcShamt) begin
      opA = rtData;
      opB = {{(dataWidth-5){1'b0}}, fields.shamt};
    end else begin
      opA = rsData;
      opB = ctrl.aluSrcImm ? extImm : rtData;
    end
  end

  always_comb begin
    case (ctrl.aluOp)
      ALU_ADD:  aluResult = opA + opB;
      ALU_SUB:  aluResult = opA - opB;
      ALU_AND:  aluResult = opA & opB;
      ALU_OR:   aluResult = opA | opB;
      ALU_XOR:  aluResult = opA ^ opB;
      ALU_NOR:  aluResult = ~(opA | opB);
      ALU_SLT:  aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
      ALU_SLTU: aluResult = {{(dataWidth-1){1'b0}}, opA < opB};
      ALU_SLL:  aluResult = opA << opB;
      ALU_SRL:  aluResult = opA >> opB; // logical, zero fill
      default:  aluResult = opA + opB;
    endcase
  end

  assign zero = (aluResult == '0);

endmodule

/* design/registerFile.sv */
module registerFile import cpuTypesPkg::*; #(
  parameter int dataWidth = 32,
  parameter int regCount  = 32
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  instrFieldsT          fields,
  input  ctrlT                 ctrl,
  input  logic                 halt,
  input  logic [dataWidth-1:0] aluResult,
  input  logic [dataWidth-1:0] memData,
  input  logic [dataWidth-1:0] linkAddr,
  output logic [dataWidth-1:0] rsData,
  output logic [dataWidth-1:0] rtData
);

  localparam int addrWidth = $clog2(regCount);

  logic [dataWidth-1:0] regs [regCount];
  logic [addrWidth-1:0] wAddr;
  logic [dataWidth-1:0] wData;

  always_comb begin
    case (ctrl.regDst)
      DST_RD:  wAddr = fields.rd[addrWidth-1:0];
      DST_RA:  wAddr = addrWidth'(regCount - 1); // link register
      default: wAddr = fields.rt[addrWidth-1:0];
    endcase
    case (ctrl.wbSrc)
      WB_MEM:  wData = memData;
      WB_LINK: wData = linkAddr;
      default: wData = aluResult;
    endcase
  end

  // register 0 is never written, so it keeps its reset value
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < regCount; i++) regs[i] <= '0;
    end else if (ctrl.regWr && !halt && wAddr != '0) begin
      regs[wAddr] <= wData;
    end
  end

  assign rsData = regs[fields.rs[addrWidth-1:0]];
  assign rtData = regs[fields.rt[addrWidth-1:0]];

endmodule

/* design/pcUnit.sv */
module pcUnit import cpuTypesPkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  ctrlT        ctrl,
  input  instrFieldsT fields,
  input  logic        zero,
  input  logic [31:0] rsData,
  input  logic        halt,
  output logic [31:0] pc,
  output logic [31:0] linkAddr
);

  logic [31:0] pcPlus4;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic [31:0] pcNext;
  logic        taken;

  assign pcPlus4  = pc + 32'd4;
  assign linkAddr = pcPlus4;

  // word offset relative to the next instruction
  assign branchTarget = pcPlus4 + {{14{fields.imm16[15]}}, fields.imm16, 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], fields.target26, 2'b00};

  assign taken = ctrl.isBranch && (zero == ctrl.branchOnZero);

  always_comb begin
    case (ctrl.pcSrc)
      PC_BRANCH: pcNext = taken ? branchTarget : pcPlus4;
      PC_JUMP:   pcNext = jumpTarget;
      PC_JREG:   pcNext = rsData;
      default:   pcNext = pcPlus4;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= '0;
    end else if (!halt) begin
      pc <= pcNext;  // frozen once halted
    end
  end

endmodule

/* design/mipsCore.sv */
module mipsCore import cpuTypesPkg::*; #(
  parameter int dataWidth = 32,
  parameter int regCount  = 32
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic [31:0]          imemLoad,
  output logic [31:0]          imemAddr,
  output logic                 iREN,
  input  logic [dataWidth-1:0] dmemLoad,
  output logic [dataWidth-1:0] dmemAddr,
  output logic [dataWidth-1:0] dmemStore,
  output logic                 dREN,
  output logic                 dWEN,
  output logic                 halt
);

  instrFieldsT          fields;
  ctrlT                 ctrl;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [dataWidth-1:0] aluResult;
  logic                 zero;
  logic [31:0]          pc;
  logic [31:0]          linkAddr;

  controlUnit i_control (
    .CLK    (CLK),
    .nRST   (nRST),
    .instr  (imemLoad),
    .fields (fields),
    .ctrl   (ctrl),
    .halt   (halt)
  );

  registerFile #(
    .dataWidth (dataWidth),
    .regCount  (regCount)
  ) i_regs (
    .CLK       (CLK),
    .nRST      (nRST),
    .fields    (fields),
    .ctrl      (ctrl),
    .halt      (halt),
    .aluResult (aluResult),
    .memData   (dmemLoad),
    .linkAddr  (linkAddr),
    .rsData    (rsData),
    .rtData    (rtData)
  );

  aluUnit #(
    .dataWidth (dataWidth)
  ) i_alu (
    .rsData    (rsData),
    .rtData    (rtData),
    .fields    (fields),
    .ctrl      (ctrl),
    .aluResult (aluResult),
    .zero      (zero)
  );

  pcUnit i_pc (
    .CLK      (CLK),
    .nRST     (nRST),
    .ctrl     (ctrl),
    .fields   (fields),
    .zero     (zero),
    .rsData   (rsData),
    .halt     (halt),
    .pc       (pc),
    .linkAddr (linkAddr)
  );

  assign imemAddr  = pc;
  assign iREN      = ~halt;
  assign dmemAddr  = aluResult;
  assign dmemStore = rtData;
  assign dREN      = ctrl.memRead & ~halt;  // no memory traffic once halted
  assign dWEN      = ctrl.memWrite & ~halt;

endmodule

/* bench/clockGen.sv */
module clockGen (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK  = 1'b0;
    nRST = 1'b0; // core held in reset from time 0
  end

  always #50 CLK = ~CLK;

  // low over three rising edges, released just after an edge
  task automatic pulseReset();
    @(posedge CLK);
    #10 nRST = 1'b0;
    repeat (3) @(posedge CLK);
    #10 nRST = 1'b1;
  endtask

endmodule

/* bench/cpuBench.sv */
module cpuBench import cpuTypesPkg::*; ();

  logic        CLK;
  logic        nRST;
  logic [31:0] imemLoad;
  logic [31:0] imemAddr;
  logic [31:0] dmemLoad;
  logic [31:0] dmemAddr;
  logic [31:0] dmemStore;
  logic        iREN;
  logic        dREN;
  logic        dWEN;
  logic        halt;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] prog [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] logAddr [$];
  logic [31:0] logData [$];

  int     errCount;
  int     passCount;
  int     failCount;
  int     cycles;
  int     budget; // 20 cycles per loaded instruction
  integer seed;

  clockGen i_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  mipsCore #(
    .dataWidth (32),
    .regCount  (32)
  ) i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .imemLoad  (imemLoad),
    .imemAddr  (imemAddr),
    .iREN      (iREN),
    .dmemLoad  (dmemLoad),
    .dmemAddr  (dmemAddr),
    .dmemStore (dmemStore),
    .dREN      (dREN),
    .dWEN      (dWEN),
    .halt      (halt)
  );

  // word addressed, combinational reads
  assign imemLoad = imem[imemAddr[9:2]];
  assign dmemLoad = dREN ? dmem[dmemAddr[9:2]] : '0; // data only on a read

  always @(posedge CLK) begin
    if (nRST && dWEN) begin
      dmem[dmemAddr[9:2]] = dmemStore;
      logAddr.push_back(dmemAddr);
      logData.push_back(dmemStore);
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > budget + 100) begin
      $display("timeout: core did not halt within %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] rType(input functT f, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] shamt);
    return {6'(RTYPE), rs, rt, rd, shamt, 6'(f)};
  endfunction

  function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {6'(op), rs, rt, imm};
  endfunction

  function automatic logic [31:0] jType(input opcodeT op, input logic [25:0] target);
    return {6'(op), target};
  endfunction

  function automatic logic [31:0] signExt16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      $display("error: %s = %h, expected %h", name, got, expected);
      errCount++;
    end
  endtask

  task automatic clearProgram();
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  // store of rt at an r0 based offset, expected in program order
  task automatic expectStore(input logic [4:0] rt, input logic [15:0] off,
                             input logic [31:0] val);
    prog.push_back(iType(SW, 0, rt, off));
    expAddr.push_back(signExt16(off));
    expData.push_back(val);
  endtask

  task automatic waitHalt();
    while (halt !== 1'b1) begin
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic runProgram();
    for (int i = 0; i < 256; i++)
      imem[i] = (i < prog.size()) ? prog[i] : jType(HALT, 26'(i)); // runaway code halts
    budget += 20 * prog.size();
    logAddr.delete();
    logData.delete();
    i_clk.pulseReset();
    waitHalt();
  endtask

  task automatic compareStores();
    checkValue("store count", logAddr.size(), expAddr.size());
    for (int i = 0; i < expAddr.size() && i < logAddr.size(); i++) begin
      checkValue("dmemAddr", logAddr[i], expAddr[i]);
      checkValue("dmemStore", logData[i], expData[i]);
    end
  endtask

  task automatic reportTest(input string name, input int startErr);
    if (errCount == startErr) begin
      $display("%s: passed", name);
      passCount++;
    end else begin
      $display("%s: failed with %0d errors", name, errCount - startErr);
      failCount++;
    end
  endtask

  task automatic arithTest();
    int          startErr;
    logic [31:0] a;
    logic [31:0] b;
    startErr = errCount;
    clearProgram();
    a = 32'hffff_fff3; // negative, for the signed compare
    b = 32'h0000_0025;
    prog.push_back(iType(ADDIU, 0, 1, a[15:0]));
    prog.push_back(iType(ORI, 0, 2, b[15:0]));
    prog.push_back(rType(ADDU, 1, 2, 3, 0));
    expectStore(3, 0, a + b);
    prog.push_back(rType(SUBU, 1, 2, 3, 0));
    expectStore(3, 4, a - b);
    prog.push_back(rType(AND, 1, 2, 3, 0));
    expectStore(3, 8, a & b);
    prog.push_back(rType(OR, 1, 2, 3, 0));
    expectStore(3, 12, a | b);
    prog.push_back(rType(XOR, 1, 2, 3, 0));
    expectStore(3, 16, a ^ b);
    prog.push_back(rType(NOR, 1, 2, 3, 0));
    expectStore(3, 20, ~(a | b));
    prog.push_back(rType(SLT, 1, 2, 3, 0));
    expectStore(3, 24, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    prog.push_back(rType(SLTU, 1, 2, 3, 0));
    expectStore(3, 28, (a < b) ? 32'd1 : 32'd0);
    prog.push_back(rType(SLL, 0, 2, 3, 4));
    expectStore(3, 32, b << 4);
    prog.push_back(rType(SRL, 0, 1, 3, 8));
    expectStore(3, 36, a >> 8);
    prog.push_back(jType(HALT, 0));
    runProgram();
    compareStores();
    reportTest("r-type arithmetic", startErr);
  endtask

  task automatic immediateTest();
    int startErr;
    startErr = errCount;
    clearProgram();
    prog.push_back(iType(ORI, 0, 3, 16'h8001));
    expectStore(3, 0, {16'h0000, 16'h8001});
    prog.push_back(iType(ADDIU, 0, 3, 16'h8001));
    expectStore(3, 4, signExt16(16'h8001));
    prog.push_back(iType(ADDIU, 0, 4, 16'hffff)); // r4 = -1
    prog.push_back(iType(ANDI, 4, 3, 16'h8f0f));
    expectStore(3, 8, {16'h0000, 16'h8f0f});
    prog.push_back(iType(XORI, 4, 3, 16'h80ff));
    expectStore(3, 12, 32'hffff_ffff ^ {16'h0000, 16'h80ff});
    prog.push_back(iType(SLTI, 0, 3, 16'hffff));  // 0 < -1 is false
    expectStore(3, 16, 32'd0);
    prog.push_back(iType(SLTI, 4, 3, 16'h0001));
    expectStore(3, 20, 32'd1);
    prog.push_back(iType(LUI, 0, 3, 16'habcd));
    expectStore(3, 24, {16'habcd, 16'h0000});
    prog.push_back(iType(ADDIU, 0, 0, 16'h1234));
    expectStore(0, 28, 32'd0);
    prog.push_back(jType(HALT, 0));
    runProgram();
    compareStores();
    reportTest("immediates", startErr);
  endtask

  task automatic memoryTest();
    int          startErr;
    logic [31:0] base;
    logic [31:0] ldAddr;
    logic [31:0] word;
    logic [15:0] ldOff;
    logic [15:0] stOff;
    logic [15:0] addImm;
    startErr = errCount;
    clearProgram();
    base = 32'h0000_0100;
    prog.push_back(iType(ADDIU, 0, 5, base[15:0]));
    for (int k = 0; k < 3; k++) begin
      ldOff  = 16'(k * 12 - 8);  // -8, 4, 16
      stOff  = 16'(k * 40 - 32); // -32, 8, 48
      ldAddr = base + signExt16(ldOff);
      word   = $random(seed);
      addImm = 16'($random(seed));
      dmem[ldAddr[9:2]] = word;
      prog.push_back(iType(LW, 5, 6, ldOff));
      prog.push_back(iType(ADDIU, 6, 6, addImm));
      prog.push_back(iType(SW, 5, 6, stOff));
      expAddr.push_back(base + signExt16(stOff));
      expData.push_back(word + signExt16(addImm));
    end
    prog.push_back(jType(HALT, 0));
    runProgram();
    compareStores();
    reportTest("memory round trip", startErr);
  endtask

  task automatic branchTest();
    int startErr;
    startErr = errCount;
    clearProgram();
    prog.push_back(iType(ADDIU, 0, 1, 16'd5));
    prog.push_back(iType(ADDIU, 0, 2, 16'd5));
    prog.push_back(iType(ADDIU, 0, 3, 16'd7));
    prog.push_back(iType(BEQ, 1, 2, 16'd1));   // taken
    prog.push_back(iType(SW, 0, 3, 16'd0));
    expectStore(1, 4, 32'd5);
    prog.push_back(iType(BEQ, 1, 3, 16'd1));   // not taken
    expectStore(3, 8, 32'd7);
    prog.push_back(iType(BNE, 1, 3, 16'd1));   // taken
    prog.push_back(iType(SW, 0, 1, 16'd12));
    prog.push_back(iType(BNE, 1, 2, 16'd1));   // not taken
    expectStore(2, 16, 32'd5);
    prog.push_back(iType(ADDIU, 0, 5, 16'd4));
    prog.push_back(iType(ADDIU, 4, 4, 16'd3)); // loop body, four passes
    prog.push_back(iType(ADDIU, 5, 5, 16'hffff));
    prog.push_back(iType(BNE, 5, 0, 16'hfffd)); // back to the body
    expectStore(4, 20, 32'd4 * 32'd3);
    prog.push_back(jType(HALT, 0));
    runProgram();
    compareStores();
    reportTest("branches", startErr);
  endtask

  task automatic jumpTest();
    int          startErr;
    logic [31:0] jalAddr;
    startErr = errCount;
    clearProgram();
    jalAddr = 32'd12;
    prog.push_back(iType(ADDIU, 0, 1, 16'd9));
    prog.push_back(jType(J, 26'd3));
    prog.push_back(iType(SW, 0, 1, 16'd0));   // jumped over
    prog.push_back(jType(JAL, 26'd6));
    prog.push_back(iType(SW, 0, 31, 16'd4));  // reached through jr
    prog.push_back(jType(HALT, 0));
    prog.push_back(iType(SW, 0, 31, 16'd8));
    prog.push_back(rType(JR, 31, 0, 0, 0));
    // execution order, subroutine store first
    expAddr.push_back(32'd8);
    expData.push_back(jalAddr + 32'd4);
    expAddr.push_back(32'd4);
    expData.push_back(jalAddr + 32'd4);
    runProgram();
    compareStores();
    reportTest("jumps", startErr);
  endtask

  task automatic haltTest();
    int          startErr;
    logic [31:0] haltAddr;
    startErr = errCount;
    clearProgram();
    haltAddr = 32'd8;
    prog.push_back(iType(ADDIU, 0, 1, 16'h0055));
    expectStore(1, 16'h0010, 32'h0000_0055);
    prog.push_back(jType(HALT, 0));
    prog.push_back(iType(SW, 0, 1, 16'h0014)); // must stay blocked
    runProgram();
    checkValue("halt", halt, 1'b1);
    checkValue("iREN", iREN, 1'b0);
    checkValue("dWEN", dWEN, 1'b0);
    repeat (10) begin
      @(posedge CLK);
      #10;
      checkValue("imemAddr", imemAddr, haltAddr + 32'd4);
      checkValue("dWEN", dWEN, 1'b0);
    end
    imem[(haltAddr >> 2) + 1] = iType(LW, 0, 2, 16'h0010); // load in the frozen slot
    #1;
    checkValue("dREN", dREN, 1'b0);
    compareStores();
    // second run from reset
    logAddr.delete();
    logData.delete();
    budget += 20 * prog.size();
    i_clk.pulseReset();
    checkValue("halt", halt, 1'b0);
    checkValue("iREN", iREN, 1'b1);
    checkValue("imemAddr", imemAddr, 32'd0);
    waitHalt();
    compareStores();
    reportTest("halt", startErr);
  endtask

  initial begin
    seed      = 32'h2f5e_3de7;
    errCount  = 0;
    passCount = 0;
    failCount = 0;
    cycles    = 0;
    budget    = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = jType(HALT, 26'(i));
      dmem[i] = {16'hda7a, 8'(i), 8'(~i)};
    end
    arithTest();
    immediateTest();
    memoryTest();
    branchTest();
    jumpTest();
    haltTest();
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* mipsCore.f */
design/cpuTypesPkg.sv
design/controlUnit.sv
design/aluUnit.sv
design/registerFile.sv
design/pcUnit.sv
design/mipsCore.sv
bench/clockGen.sv
bench/cpuBench.sv
